/* common/exec_pkg.sv */
package exec_pkg;

  // datapath and tag widths
  localparam int WORD_W = 32;
  localparam int ROB_W  = 4;
  localparam int REG_W  = 5;

  // issued operations
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_SLT,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_MUL
  } opcode_e;

  // functional unit slots, also the index into per-unit vectors
  typedef enum logic [1:0] {
    FU_ALU,
    FU_LOGIC,
    FU_BRANCH,
    FU_MULT
  } fu_e;

  // mult is the last slot
  localparam int NUM_FU = int'(FU_MULT) + 1;

  // four-phase receiver states in decode
  typedef enum logic [1:0] {
    HS_IDLE,
    HS_ACKED,
    HS_WAIT_RELEASE
  } hs_state_e;

endpackage

/* verilog/issue_decode.sv */
`timescale 1ns/1ps

module issue_decode #(
  parameter int MULT_STAGES = 6
)
( input                                 clk_i
 , input                                reset_i
 , input                                issue_req_i
 , input        [exec_pkg::ROB_W-1:0]   issue_rob_i
 , input        [exec_pkg::REG_W-1:0]   issue_reg_i
 , input  exec_pkg::opcode_e            issue_op_i
 , input        [exec_pkg::WORD_W-1:0]  issue_src1_i
 , input        [exec_pkg::WORD_W-1:0]  issue_src2_i
 , input                                issue_imm_v_i
 , input        [exec_pkg::WORD_W-1:0]  issue_imm_i
 , output logic                         issue_ack_o
 , output logic [exec_pkg::NUM_FU-1:0]  fu_v_o
 , output exec_pkg::opcode_e            op_o
 , output logic [exec_pkg::WORD_W-1:0]  operand1_o
 , output logic [exec_pkg::WORD_W-1:0]  operand2_o
 , output logic [exec_pkg::ROB_W-1:0]   rob_o
 , output logic [exec_pkg::REG_W-1:0]   reg_o
);

  import exec_pkg::*;

  hs_state_e              state_q;
  fu_e                    unit;
  logic [WORD_W-1:0]      operand2;
  logic [MULT_STAGES-1:0] mult_sr_q;
  logic [MULT_STAGES:0]   mult_window;
  logic                   collide;
  logic                   accept;

  always_comb begin
    case (issue_op_i)
      OP_ADD, OP_SUB, OP_SLT: unit = FU_ALU;
      OP_BEQ, OP_BNE, OP_BLT: unit = FU_BRANCH;
      OP_MUL:                 unit = FU_MULT;
      default:                unit = FU_LOGIC;
    endcase
  end

  assign operand2 = issue_imm_v_i ? issue_imm_i : issue_src2_i;

  // bit k of the window is a multiply dispatched k cycles ago;
  // a single-cycle op now would land on the bus with it
  assign mult_window = {mult_sr_q, 1'b0};
  assign collide     = mult_window[MULT_STAGES-1] && (unit != FU_MULT);
  assign accept      = (state_q == HS_IDLE) && issue_req_i && !collide;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= HS_IDLE;
      issue_ack_o <= 1'b0;
      fu_v_o      <= '0;
      mult_sr_q   <= '0;
    end else begin
      fu_v_o    <= '0;
      mult_sr_q <= (mult_sr_q << 1) | MULT_STAGES'(accept && (unit == FU_MULT));
      case (state_q)
        HS_IDLE: begin
          if (accept) begin
            issue_ack_o <= 1'b1;
            fu_v_o      <= NUM_FU'(1) << unit;
            state_q     <= HS_ACKED;
          end
        end
        HS_ACKED: state_q <= HS_WAIT_RELEASE;
        HS_WAIT_RELEASE: begin
          // release phase
          if (!issue_req_i) begin
            issue_ack_o <= 1'b0;
            state_q     <= HS_IDLE;
          end
        end
        default: state_q <= HS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_o       <= issue_op_i;
      operand1_o <= issue_src1_i;
      operand2_o <= operand2;
      rob_o      <= issue_rob_i;
      reg_o      <= issue_reg_i;
    end
  end

  // the source holds its request until the ack rises
  a_req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (issue_req_i && !issue_ack_o) |=> issue_req_i);

endmodule

/* execute/fu_alu.sv */
`timescale 1ns/1ps

module fu_alu
( input                                 clk_i
 , input                                reset_i
 , input                                exe_v_i
 , input  exec_pkg::opcode_e            opcode_i
 , input        [exec_pkg::WORD_W-1:0]  operand1_i
 , input        [exec_pkg::WORD_W-1:0]  operand2_i
 , input        [exec_pkg::ROB_W-1:0]   rob_dest_i
 , input        [exec_pkg::REG_W-1:0]   reg_dest_i
 , output logic                         alu_v_o
 , output logic [exec_pkg::ROB_W-1:0]   alu_rob_o
 , output logic [exec_pkg::REG_W-1:0]   alu_reg_o
 , output logic [exec_pkg::WORD_W-1:0]  alu_value_o
);

  import exec_pkg::*;

  logic [WORD_W-1:0] result;

  always_comb begin
    case (opcode_i)
      OP_SUB:  result = operand1_i - operand2_i;
      // signed compare, 1 or 0
      OP_SLT:  result = WORD_W'($signed(operand1_i) < $signed(operand2_i));
      default: result = operand1_i + operand2_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alu_v_o <= 1'b0;
    end else begin
      alu_v_o <= exe_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      alu_rob_o   <= rob_dest_i;
      alu_reg_o   <= reg_dest_i;
      alu_value_o <= result;
    end
  end

endmodule

/* execute/fu_logic.sv */
`timescale 1ns/1ps

module fu_logic
( input                                 clk_i
 , input                                reset_i
 , input                                exe_v_i
 , input  exec_pkg::opcode_e            opcode_i
 , input        [exec_pkg::WORD_W-1:0]  operand1_i
 , input        [exec_pkg::WORD_W-1:0]  operand2_i
 , input        [exec_pkg::ROB_W-1:0]   rob_dest_i
 , input        [exec_pkg::REG_W-1:0]   reg_dest_i
 , output logic                         logic_v_o
 , output logic [exec_pkg::ROB_W-1:0]   logic_rob_o
 , output logic [exec_pkg::REG_W-1:0]   logic_reg_o
 , output logic [exec_pkg::WORD_W-1:0]  logic_value_o
);

  import exec_pkg::*;

  localparam int SHAMT_W = $clog2(WORD_W);

  logic [SHAMT_W-1:0] shamt;
  logic [WORD_W-1:0]  result;

  assign shamt = operand2_i[SHAMT_W-1:0];

  always_comb begin
    case (opcode_i)
      OP_OR:   result = operand1_i | operand2_i;
      OP_XOR:  result = operand1_i ^ operand2_i;
      OP_SLL:  result = operand1_i << shamt;
      OP_SRL:  result = operand1_i >> shamt;
      default: result = operand1_i & operand2_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      logic_v_o <= 1'b0;
    end else begin
      logic_v_o <= exe_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      logic_rob_o   <= rob_dest_i;
      logic_reg_o   <= reg_dest_i;
      logic_value_o <= result;
    end
  end

endmodule

/* execute/fu_branch.sv */
`timescale 1ns/1ps

module fu_branch
( input                                 clk_i
 , input                                reset_i
 , input                                exe_v_i
 , input  exec_pkg::opcode_e            opcode_i
 , input        [exec_pkg::WORD_W-1:0]  operand1_i
 , input        [exec_pkg::WORD_W-1:0]  operand2_i
 , input        [exec_pkg::ROB_W-1:0]   rob_dest_i
 , input        [exec_pkg::REG_W-1:0]   reg_dest_i
 , output logic                         branch_v_o
 , output logic [exec_pkg::ROB_W-1:0]   branch_rob_o
 , output logic [exec_pkg::REG_W-1:0]   branch_reg_o
 , output logic [exec_pkg::WORD_W-1:0]  branch_value_o
 , output logic                         branch_taken_o
);

  import exec_pkg::*;

  logic              taken;
  logic [WORD_W-1:0] target;

  always_comb begin
    case (opcode_i)
      OP_BNE:  taken = operand1_i != operand2_i;
      OP_BLT:  taken = $signed(operand1_i) < $signed(operand2_i);
      default: taken = operand1_i == operand2_i;
    endcase
  end

  // reported even when not taken
  assign target = operand1_i + operand2_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      branch_v_o <= 1'b0;
    end else begin
      branch_v_o <= exe_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_v_i) begin
      branch_rob_o   <= rob_dest_i;
      branch_reg_o   <= reg_dest_i;
      branch_value_o <= target;
      branch_taken_o <= taken;
    end
  end

endmodule

/* execute/fu_mult.sv */
`timescale 1ns/1ps

module fu_mult #(
  parameter int MULT_STAGES = 6
)
( input                                 clk_i
 , input                                reset_i
 , input                                exe_v_i
 , input        [exec_pkg::WORD_W-1:0]  operand1_i
 , input        [exec_pkg::WORD_W-1:0]  operand2_i
 , input        [exec_pkg::ROB_W-1:0]   rob_dest_i
 , input        [exec_pkg::REG_W-1:0]   reg_dest_i
 , output logic                         mult_v_o
 , output logic [exec_pkg::ROB_W-1:0]   mult_rob_o
 , output logic [exec_pkg::REG_W-1:0]   mult_reg_o
 , output logic [exec_pkg::WORD_W-1:0]  mult_value_o
);

  import exec_pkg::*;

  // stage 0 takes the product, the rest only carry it
  logic [MULT_STAGES-1:0] v_q;
  logic [ROB_W-1:0]       rob_q   [MULT_STAGES];
  logic [REG_W-1:0]       reg_q   [MULT_STAGES];
  logic [WORD_W-1:0]      value_q [MULT_STAGES];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_q <= '0;
    end else begin
      v_q <= (v_q << 1) | MULT_STAGES'(exe_v_i);
    end
  end

  // payload shifts every cycle, bubbles ride along with v_q low
  always_ff @(posedge clk_i) begin
    rob_q[0]   <= rob_dest_i;
    reg_q[0]   <= reg_dest_i;
    value_q[0] <= operand1_i * operand2_i;
    for (int i = 1; i < MULT_STAGES; i++) begin
      rob_q[i]   <= rob_q[i-1];
      reg_q[i]   <= reg_q[i-1];
      value_q[i] <= value_q[i-1];
    end
  end

  assign mult_v_o     = v_q[MULT_STAGES-1];
  assign mult_rob_o   = rob_q[MULT_STAGES-1];
  assign mult_reg_o   = reg_q[MULT_STAGES-1];
  assign mult_value_o = value_q[MULT_STAGES-1];

endmodule

/* verilog/result_bus.sv */
`timescale 1ns/1ps

module result_bus
( input                                 clk_i
 , input                                reset_i
 , input                                alu_v_i
 , input        [exec_pkg::ROB_W-1:0]   alu_rob_i
 , input        [exec_pkg::REG_W-1:0]   alu_reg_i
 , input        [exec_pkg::WORD_W-1:0]  alu_value_i
 , input                                logic_v_i
 , input        [exec_pkg::ROB_W-1:0]   logic_rob_i
 , input        [exec_pkg::REG_W-1:0]   logic_reg_i
 , input        [exec_pkg::WORD_W-1:0]  logic_value_i
 , input                                branch_v_i
 , input        [exec_pkg::ROB_W-1:0]   branch_rob_i
 , input        [exec_pkg::REG_W-1:0]   branch_reg_i
 , input        [exec_pkg::WORD_W-1:0]  branch_value_i
 , input                                branch_taken_i
 , input                                mult_v_i
 , input        [exec_pkg::ROB_W-1:0]   mult_rob_i
 , input        [exec_pkg::REG_W-1:0]   mult_reg_i
 , input        [exec_pkg::WORD_W-1:0]  mult_value_i
 , output logic                         result_v_o
 , output logic [exec_pkg::ROB_W-1:0]   result_rob_o
 , output logic [exec_pkg::REG_W-1:0]   result_reg_o
 , output logic                         result_we_o
 , output logic [exec_pkg::WORD_W-1:0]  result_value_o
 , output logic                         result_taken_o
);

  import exec_pkg::*;

  logic [NUM_FU-1:0] unit_v;
  logic [ROB_W-1:0]  unit_rob   [NUM_FU];
  logic [REG_W-1:0]  unit_reg   [NUM_FU];
  logic [WORD_W-1:0] unit_value [NUM_FU];
  logic [ROB_W-1:0]  sel_rob;
  logic [REG_W-1:0]  sel_reg;
  logic [WORD_W-1:0] sel_value;
  logic              sel_we;
  logic              sel_taken;

  // unit slots
  assign unit_v[FU_ALU]        = alu_v_i;
  assign unit_rob[FU_ALU]      = alu_rob_i;
  assign unit_reg[FU_ALU]      = alu_reg_i;
  assign unit_value[FU_ALU]    = alu_value_i;
  assign unit_v[FU_LOGIC]      = logic_v_i;
  assign unit_rob[FU_LOGIC]    = logic_rob_i;
  assign unit_reg[FU_LOGIC]    = logic_reg_i;
  assign unit_value[FU_LOGIC]  = logic_value_i;
  assign unit_v[FU_BRANCH]     = branch_v_i;
  assign unit_rob[FU_BRANCH]   = branch_rob_i;
  assign unit_reg[FU_BRANCH]   = branch_reg_i;
  assign unit_value[FU_BRANCH] = branch_value_i;
  assign unit_v[FU_MULT]       = mult_v_i;
  assign unit_rob[FU_MULT]     = mult_rob_i;
  assign unit_reg[FU_MULT]     = mult_reg_i;
  assign unit_value[FU_MULT]   = mult_value_i;

  // and-or merge, valid since at most one unit completes
  always_comb begin
    sel_rob   = '0;
    sel_reg   = '0;
    sel_value = '0;
    for (int i = 0; i < NUM_FU; i++) begin
      sel_rob   |= unit_rob[i] & {ROB_W{unit_v[i]}};
      sel_reg   |= unit_reg[i] & {REG_W{unit_v[i]}};
      sel_value |= unit_value[i] & {WORD_W{unit_v[i]}};
    end
  end

  // branches never write a register
  assign sel_we    = (|unit_v) && !unit_v[FU_BRANCH];
  assign sel_taken = unit_v[FU_BRANCH] && branch_taken_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_v_o     <= 1'b0;
      result_we_o    <= 1'b0;
      result_taken_o <= 1'b0;
    end else begin
      result_v_o     <= |unit_v;
      result_we_o    <= sel_we;
      result_taken_o <= sel_taken;
    end
  end

  always_ff @(posedge clk_i) begin
    result_rob_o   <= sel_rob;
    result_reg_o   <= sel_reg;
    result_value_o <= sel_value;
  end

  // decode spaces dispatches so the units never complete together
  a_one_completion: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(unit_v));

endmodule

/* verilog/execute_top.sv */
`timescale 1ns/1ps

module execute_top #(
  parameter int MULT_STAGES = 6
)
( input                                 clk_i
 , input                                reset_i
 , input                                issue_req_i
 , input        [exec_pkg::ROB_W-1:0]   issue_rob_i
 , input        [exec_pkg::REG_W-1:0]   issue_reg_i
 , input  exec_pkg::opcode_e            issue_op_i
 , input        [exec_pkg::WORD_W-1:0]  issue_src1_i
 , input        [exec_pkg::WORD_W-1:0]  issue_src2_i
 , input                                issue_imm_v_i
 , input        [exec_pkg::WORD_W-1:0]  issue_imm_i
 , output logic                         issue_ack_o
 , output logic                         result_v_o
 , output logic [exec_pkg::ROB_W-1:0]   result_rob_o
 , output logic [exec_pkg::REG_W-1:0]   result_reg_o
 , output logic                         result_we_o
 , output logic [exec_pkg::WORD_W-1:0]  result_value_o
 , output logic                         result_taken_o
);

  import exec_pkg::*;

  // dispatch wires shared by all units
  logic [NUM_FU-1:0] fu_v;
  opcode_e           op;
  logic [WORD_W-1:0] operand1;
  logic [WORD_W-1:0] operand2;
  logic [ROB_W-1:0]  rob_dest;
  logic [REG_W-1:0]  reg_dest;

  logic              alu_v;
  logic [ROB_W-1:0]  alu_rob;
  logic [REG_W-1:0]  alu_reg;
  logic [WORD_W-1:0] alu_value;
  logic              logic_v;
  logic [ROB_W-1:0]  logic_rob;
  logic [REG_W-1:0]  logic_reg;
  logic [WORD_W-1:0] logic_value;
  logic              branch_v;
  logic [ROB_W-1:0]  branch_rob;
  logic [REG_W-1:0]  branch_reg;
  logic [WORD_W-1:0] branch_value;
  logic              branch_taken;
  logic              mult_v;
  logic [ROB_W-1:0]  mult_rob;
  logic [REG_W-1:0]  mult_reg;
  logic [WORD_W-1:0] mult_value;

  issue_decode #(
    .MULT_STAGES(MULT_STAGES)
  ) decode
  ( .clk_i        (clk_i)
   ,.reset_i      (reset_i)
   ,.issue_req_i  (issue_req_i)
   ,.issue_rob_i  (issue_rob_i)
   ,.issue_reg_i  (issue_reg_i)
   ,.issue_op_i   (issue_op_i)
   ,.issue_src1_i (issue_src1_i)
   ,.issue_src2_i (issue_src2_i)
   ,.issue_imm_v_i(issue_imm_v_i)
   ,.issue_imm_i  (issue_imm_i)
   ,.issue_ack_o  (issue_ack_o)
   ,.fu_v_o       (fu_v)
   ,.op_o         (op)
   ,.operand1_o   (operand1)
   ,.operand2_o   (operand2)
   ,.rob_o        (rob_dest)
   ,.reg_o        (reg_dest)
  );

  fu_alu alu_fu
  ( .clk_i      (clk_i)
   ,.reset_i    (reset_i)
   ,.exe_v_i    (fu_v[FU_ALU])
   ,.opcode_i   (op)
   ,.operand1_i (operand1)
   ,.operand2_i (operand2)
   ,.rob_dest_i (rob_dest)
   ,.reg_dest_i (reg_dest)
   ,.alu_v_o    (alu_v)
   ,.alu_rob_o  (alu_rob)
   ,.alu_reg_o  (alu_reg)
   ,.alu_value_o(alu_value)
  );

  fu_logic logic_fu
  ( .clk_i        (clk_i)
   ,.reset_i      (reset_i)
   ,.exe_v_i      (fu_v[FU_LOGIC])
   ,.opcode_i     (op)
   ,.operand1_i   (operand1)
   ,.operand2_i   (operand2)
   ,.rob_dest_i   (rob_dest)
   ,.reg_dest_i   (reg_dest)
   ,.logic_v_o    (logic_v)
   ,.logic_rob_o  (logic_rob)
   ,.logic_reg_o  (logic_reg)
   ,.logic_value_o(logic_value)
  );

  fu_branch branch_fu
  ( .clk_i         (clk_i)
   ,.reset_i       (reset_i)
   ,.exe_v_i       (fu_v[FU_BRANCH])
   ,.opcode_i      (op)
   ,.operand1_i    (operand1)
   ,.operand2_i    (operand2)
   ,.rob_dest_i    (rob_dest)
   ,.reg_dest_i    (reg_dest)
   ,.branch_v_o    (branch_v)
   ,.branch_rob_o  (branch_rob)
   ,.branch_reg_o  (branch_reg)
   ,.branch_value_o(branch_value)
   ,.branch_taken_o(branch_taken)
  );

  fu_mult #(
    .MULT_STAGES(MULT_STAGES)
  ) mult_fu
  ( .clk_i       (clk_i)
   ,.reset_i     (reset_i)
   ,.exe_v_i     (fu_v[FU_MULT])
   ,.operand1_i  (operand1)
   ,.operand2_i  (operand2)
   ,.rob_dest_i  (rob_dest)
   ,.reg_dest_i  (reg_dest)
   ,.mult_v_o    (mult_v)
   ,.mult_rob_o  (mult_rob)
   ,.mult_reg_o  (mult_reg)
   ,.mult_value_o(mult_value)
  );

  result_bus cdb
  ( .clk_i         (clk_i)
   ,.reset_i       (reset_i)
   ,.alu_v_i       (alu_v)
   ,.alu_rob_i     (alu_rob)
   ,.alu_reg_i     (alu_reg)
   ,.alu_value_i   (alu_value)
   ,.logic_v_i     (logic_v)
   ,.logic_rob_i   (logic_rob)
   ,.logic_reg_i   (logic_reg)
   ,.logic_value_i (logic_value)
   ,.branch_v_i    (branch_v)
   ,.branch_rob_i  (branch_rob)
   ,.branch_reg_i  (branch_reg)
   ,.branch_value_i(branch_value)
   ,.branch_taken_i(branch_taken)
   ,.mult_v_i      (mult_v)
   ,.mult_rob_i    (mult_rob)
   ,.mult_reg_i    (mult_reg)
   ,.mult_value_i  (mult_value)
   ,.result_v_o    (result_v_o)
   ,.result_rob_o  (result_rob_o)
   ,.result_reg_o  (result_reg_o)
   ,.result_we_o   (result_we_o)
   ,.result_value_o(result_value_o)
   ,.result_taken_o(result_taken_o)
  );

endmodule

/* sim/execute_tb.sv */
`timescale 1ns/1ps

module execute_tb;

  import exec_pkg::*;

  localparam int MULT_STAGES = 6;
  localparam int CLK_PERIOD  = 20;
  localparam int ACK_LIMIT   = 8;

  localparam int NUM_ARITH  = 24;
  localparam int NUM_BRANCH = 12;
  localparam int NUM_MUL    = 8;
  localparam int NUM_PAIRS  = 8;
  localparam int NUM_MIXED  = 32;
  localparam int NUM_INSTR  = NUM_ARITH + NUM_BRANCH + NUM_MUL + 2 * NUM_PAIRS + NUM_MIXED;

  // handshake, idle gap, hazard stall and the full multiply latency
  localparam int CYCLES_PER_INSTR = MULT_STAGES + 12;
  localparam int TIMEOUT_NS       = (NUM_INSTR * CYCLES_PER_INSTR + 20) * CLK_PERIOD;

  // gap that puts a single-cycle op on a multiply's completion cycle
  localparam int COLLIDE_GAP = (MULT_STAGES > 5) ? MULT_STAGES - 5 : 0;

  logic              clk_i;
  logic              reset_i;
  logic              issue_req_i;
  logic [ROB_W-1:0]  issue_rob_i;
  logic [REG_W-1:0]  issue_reg_i;
  opcode_e           issue_op_i;
  logic [WORD_W-1:0] issue_src1_i;
  logic [WORD_W-1:0] issue_src2_i;
  logic              issue_imm_v_i;
  logic [WORD_W-1:0] issue_imm_i;
  logic              issue_ack_o;
  logic              result_v_o;
  logic [ROB_W-1:0]  result_rob_o;
  logic [REG_W-1:0]  result_reg_o;
  logic              result_we_o;
  logic [WORD_W-1:0] result_value_o;
  logic              result_taken_o;

  // expectations per rob tag
  logic [WORD_W-1:0] exp_value [16];
  logic              exp_we    [16];
  logic              exp_taken [16];
  logic [REG_W-1:0]  exp_reg   [16];
  int                issued_cnt [16];
  int                returned_cnt [16] = '{default: 0};
  int                issued_total;
  int                returned_total = 0;

  logic [31:0]       lfsr_q;
  logic [ROB_W-1:0]  next_tag;
  int                cycle_count = 0;
  logic              ack_prev = 1'b0;

  execute_top #(
    .MULT_STAGES(MULT_STAGES)
  ) uut
  ( .clk_i         (clk_i)
   ,.reset_i       (reset_i)
   ,.issue_req_i   (issue_req_i)
   ,.issue_rob_i   (issue_rob_i)
   ,.issue_reg_i   (issue_reg_i)
   ,.issue_op_i    (issue_op_i)
   ,.issue_src1_i  (issue_src1_i)
   ,.issue_src2_i  (issue_src2_i)
   ,.issue_imm_v_i (issue_imm_v_i)
   ,.issue_imm_i   (issue_imm_i)
   ,.issue_ack_o   (issue_ack_o)
   ,.result_v_o    (result_v_o)
   ,.result_rob_o  (result_rob_o)
   ,.result_reg_o  (result_reg_o)
   ,.result_we_o   (result_we_o)
   ,.result_value_o(result_value_o)
   ,.result_taken_o(result_taken_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic end_with_failure();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] want);
    if (got !== want) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
      end_with_failure();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
  endtask

  // returns {taken, we, value}
  function automatic logic [WORD_W+1:0] reference_result(input opcode_e op,
      input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b);
    logic [WORD_W-1:0] value;
    logic              we;
    logic              taken;
    we    = 1'b1;
    taken = 1'b0;
    case (op)
      OP_ADD: value = a + b;
      OP_SUB: value = a - b;
      OP_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_AND: value = a & b;
      OP_OR:  value = a | b;
      OP_XOR: value = a ^ b;
      OP_SLL: value = a << b[4:0];
      OP_SRL: value = a >> b[4:0];
      OP_BEQ, OP_BNE, OP_BLT: begin
        // target is reported even when not taken
        value = a + b;
        we    = 1'b0;
        if (op == OP_BEQ) taken = (a == b);
        else if (op == OP_BNE) taken = (a != b);
        else taken = ($signed(a) < $signed(b));
      end
      default: value = a * b;
    endcase
    return {taken, we, value};
  endfunction

  task automatic issue_instr(input opcode_e op, input int gap, input logic force_equal);
    logic [31:0]       bits;
    logic [31:0]       src1;
    logic [31:0]       src2;
    logic [31:0]       imm;
    logic              imm_v;
    logic [REG_W-1:0]  rd;
    logic [ROB_W-1:0]  tag;
    logic [WORD_W+1:0] expect_bits;
    int                waited;
    take_bits(32, src1);
    take_bits(32, src2);
    take_bits(32, imm);
    take_bits(1, bits);
    imm_v = bits[0];
    take_bits(REG_W, bits);
    rd = bits[REG_W-1:0];
    if (force_equal) begin
      src2  = src1;
      imm_v = 1'b0;
    end
    tag      = next_tag;
    next_tag = next_tag + 4'd1;
    // tag reuse only once its last result is back
    while (issued_cnt[tag] != returned_cnt[tag]) begin
      @(negedge clk_i);
    end
    expect_bits      = reference_result(op, src1, imm_v ? imm : src2);
    exp_value[tag]   = expect_bits[WORD_W-1:0];
    exp_we[tag]      = expect_bits[WORD_W];
    exp_taken[tag]   = expect_bits[WORD_W+1];
    exp_reg[tag]     = rd;
    issued_cnt[tag]  = issued_cnt[tag] + 1;
    issued_total     = issued_total + 1;
    repeat (gap) @(posedge clk_i);
    @(posedge clk_i);
    issue_rob_i   <= tag;
    issue_reg_i   <= rd;
    issue_op_i    <= op;
    issue_src1_i  <= src1;
    issue_src2_i  <= src2;
    issue_imm_v_i <= imm_v;
    issue_imm_i   <= imm;
    issue_req_i   <= 1'b1;
    waited = 0;
    @(negedge clk_i);
    while (issue_ack_o !== 1'b1) begin
      waited++;
      if (waited > ACK_LIMIT) begin
        $display("issue_ack_o never rose for rob tag %0d", tag);
        end_with_failure();
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    issue_req_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (issue_ack_o !== 1'b0) begin
      waited++;
      if (waited > ACK_LIMIT) begin
        $display("issue_ack_o stayed high after the request dropped, rob tag %0d", tag);
        end_with_failure();
      end
      @(negedge clk_i);
    end
  endtask

  // reset values and four-phase ordering
  always @(negedge clk_i) begin
    if (cycle_count > 0 && reset_i === 1'b1) begin
      if (issue_ack_o !== 1'b0 || result_v_o !== 1'b0) begin
        $display("issue_ack_o or result_v_o was not low during reset");
        end_with_failure();
      end
    end else if (cycle_count > 0) begin
      if (issue_ack_o && !ack_prev && !issue_req_i) begin
        $display("issue_ack_o rose while issue_req_i was low");
        end_with_failure();
      end
      if (!issue_ack_o && ack_prev && issue_req_i) begin
        $display("issue_ack_o fell before issue_req_i dropped");
        end_with_failure();
      end
    end
    ack_prev = issue_ack_o;
  end

  always @(negedge clk_i) begin
    if (reset_i === 1'b0 && result_v_o === 1'b1) begin
      if (issued_cnt[result_rob_o] == returned_cnt[result_rob_o]) begin
        $display("result arrived for rob tag %0d, which is not outstanding", result_rob_o);
        end_with_failure();
      end
      check_value("result_reg_o", 32'(result_reg_o), 32'(exp_reg[result_rob_o]));
      check_value("result_value_o", result_value_o, exp_value[result_rob_o]);
      check_value("result_we_o", 32'(result_we_o), 32'(exp_we[result_rob_o]));
      check_value("result_taken_o", 32'(result_taken_o), 32'(exp_taken[result_rob_o]));
      returned_cnt[result_rob_o] = returned_cnt[result_rob_o] + 1;
      returned_total = returned_total + 1;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns with results still missing", TIMEOUT_NS);
    end_with_failure();
  end

  initial begin
    logic [31:0] bits;
    opcode_e     op;
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    issue_req_i   = 1'b0;
    issue_rob_i   = '0;
    issue_reg_i   = '0;
    issue_op_i    = OP_ADD;
    issue_src1_i  = '0;
    issue_src2_i  = '0;
    issue_imm_v_i = 1'b0;
    issue_imm_i   = '0;
    lfsr_q        = 32'd98593;
    next_tag      = '0;
    issued_total  = 0;
    for (int i = 0; i < 16; i++) begin
      issued_cnt[i] = 0;
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    // adder and logic ops
    for (int i = 0; i < NUM_ARITH; i++) begin
      take_bits(3, bits);
      issue_instr(opcode_e'({1'b0, bits[2:0]}), 0, 1'b0);
    end
    // branches with some equal operands
    for (int i = 0; i < NUM_BRANCH; i++) begin
      take_bits(3, bits);
      case (bits[1:0])
        2'd0:    op = OP_BEQ;
        2'd1:    op = OP_BNE;
        default: op = OP_BLT;
      endcase
      issue_instr(op, 0, bits[2]);
    end
    // back to back so two multiplies overlap
    for (int i = 0; i < NUM_MUL; i++) begin
      issue_instr(OP_MUL, 0, 1'b0);
    end
    // single-cycle op aimed at the multiply writeback slot
    for (int i = 0; i < NUM_PAIRS; i++) begin
      issue_instr(OP_MUL, 0, 1'b0);
      take_bits(3, bits);
      issue_instr(opcode_e'({1'b0, bits[2:0]}), COLLIDE_GAP, 1'b0);
    end
    for (int i = 0; i < NUM_MIXED; i++) begin
      take_bits(4, bits);
      op = (bits[3:0] > 4'd11) ? OP_MUL : opcode_e'(bits[3:0]);
      take_bits(3, bits);
      issue_instr(op, int'(bits[1:0]), bits[2]);
    end

    while (returned_total != issued_total) begin
      @(negedge clk_i);
    end
    // stray results would show up here
    repeat (MULT_STAGES + 4) @(negedge clk_i);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* execute_top.f */
common/exec_pkg.sv
verilog/issue_decode.sv
execute/fu_alu.sv
execute/fu_logic.sv
execute/fu_branch.sv
execute/fu_mult.sv
verilog/result_bus.sv
verilog/execute_top.sv
sim/execute_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module execute_tb \
  -f execute_top.f \
  --Mdir obj_dir -o execute_sim

./obj_dir/execute_sim 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
exit 0
